/* logic/spi_bridge_pkg.sv */
package spi_bridge_pkg;

  ////////////////////
  // frame format
  ////////////////////

  // bits in a well formed frame, address byte first
  localparam int frame_bits = 16;
  // counter parks one past a full frame on overrun
  localparam int bit_cnt_max = frame_bits + 1;
  localparam int bit_cnt_w = $clog2(bit_cnt_max + 1);

  // field widths of the board registers
  localparam int byte_bits = 8;
  localparam int mux_bits = 8;
  localparam int dac_bits = 4;

  ////////////////////
  // register map
  ////////////////////

  localparam logic [byte_bits-1:0] addr_led = 8'd7;
  localparam logic [byte_bits-1:0] addr_mux = 8'd8;
  localparam logic [byte_bits-1:0] addr_dac = 8'd9;
  localparam logic [byte_bits-1:0] addr_soft_reset = 8'd10;

  // only this data byte at addr_soft_reset clears the board registers
  localparam logic [byte_bits-1:0] soft_reset_key = 8'ha5;

  // bad frame counter sticks here
  localparam logic [byte_bits-1:0] bad_count_max = 8'd255;

  ////////////////////
  // shared types
  ////////////////////

  // host pins after the synchronizer
  typedef struct packed {
    logic sclk;
    logic ss_n;
    logic mosi;
    logic reg_access_n;
  } spi_pins_t;

  // bus at rest, ss_n and reg_access_n high
  localparam spi_pins_t pins_idle = '{sclk: 1'b0, ss_n: 1'b1, mosi: 1'b0, reg_access_n: 1'b1};

  // one decoded register write
  typedef struct packed {
    logic [byte_bits-1:0] addr;
    logic [byte_bits-1:0] data;
  } reg_write_t;

  // board control state
  typedef struct packed {
    logic [byte_bits-1:0] led;
    logic [mux_bits-1:0]  mux;
    logic [dac_bits-1:0]  dac;
  } board_ctrl_t;

endpackage

/* logic/spi_frame_rx.sv */
`timescale 1ns/100ps

module spi_frame_rx
  import spi_bridge_pkg::*;
(
  input  logic                 cs,
  input  logic                 rst,
  input  logic                 sclk,
  input  logic                 ss_n,
  input  logic                 mosi,
  input  logic                 reg_access_n,
  output spi_pins_t            pins,
  output reg_write_t           wr,
  output logic                 wr_valid,
  output logic [byte_bits-1:0] bad_frame_count
);

  // raw host pins, bundled so both stages move as one
  spi_pins_t pins_raw;
  spi_pins_t sync_1;
  spi_pins_t sync_2;

  // last cycle's sclk and ss_n for edge detect
  logic sclk_q;
  logic ss_n_q;
  logic sclk_fall;
  logic ss_fall;
  logic ss_rise;

  // frame state
  logic [frame_bits-1:0] shift_q;
  logic [bit_cnt_w-1:0]  bit_cnt;
  // stays set while reg_access_n is low since ss_n fell
  logic                  reg_mode_ok;
  logic                  frame_good;
  logic                  frame_bad;

  ////////////////////
  // synchronizer
  ////////////////////

  assign pins_raw = '{sclk: sclk, ss_n: ss_n, mosi: mosi, reg_access_n: reg_access_n};

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      sync_1 <= pins_idle;
      sync_2 <= pins_idle;
      sclk_q <= 1'b0;
      ss_n_q <= 1'b1;
    end
    else
    begin
      sync_1 <= pins_raw;
      sync_2 <= sync_1;
      sclk_q <= sync_2.sclk;
      ss_n_q <= sync_2.ss_n;
    end
  end

  // second stage goes straight to the router
  assign pins = sync_2;

  assign sclk_fall = sclk_q & ~sync_2.sclk;
  assign ss_fall   = ss_n_q & ~sync_2.ss_n;
  assign ss_rise   = ~ss_n_q & sync_2.ss_n;

  ////////////////////
  // shift and count
  ////////////////////

  // msb first, mosi taken at each sclk fall
  always_ff @(posedge cs)
  begin
    if (!sync_2.ss_n && sclk_fall)
      shift_q <= {shift_q[frame_bits-2:0], sync_2.mosi};
  end

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      bit_cnt     <= '0;
      reg_mode_ok <= 1'b0;
    end
    else if (ss_fall)
    begin
      // new frame
      bit_cnt     <= '0;
      reg_mode_ok <= ~sync_2.reg_access_n;
    end
    else if (!sync_2.ss_n)
    begin
      // saturate at 17, anything above 16 is just too long
      if (sclk_fall && bit_cnt != bit_cnt_w'(bit_cnt_max))
        bit_cnt <= bit_cnt + 1'b1;
      // a blip into pass-through spoils the frame
      if (sync_2.reg_access_n)
        reg_mode_ok <= 1'b0;
    end
  end

  ////////////////////
  // frame end
  ////////////////////

  // judged on the ss_n rise, pass-through frames ignored
  assign frame_good = ss_rise && reg_mode_ok && bit_cnt == bit_cnt_w'(frame_bits);
  assign frame_bad  = ss_rise && reg_mode_ok && bit_cnt != bit_cnt_w'(frame_bits);

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      wr_valid        <= 1'b0;
      bad_frame_count <= '0;
    end
    else
    begin
      wr_valid <= frame_good;
      if (frame_bad && bad_frame_count != bad_count_max)
        bad_frame_count <= bad_frame_count + 1'b1;
    end
  end

  // high byte address, low byte data
  always_ff @(posedge cs)
  begin
    if (frame_good)
      wr <= reg_write_t'(shift_q);
  end

  // counter only climbs or holds between resets
  a_bad_count_monotonic: assert property (
    @(posedge cs) disable iff (rst)
    bad_frame_count >= $past(bad_frame_count)
  );

endmodule

/* logic/reg_bank.sv */
`timescale 1ns/100ps

module reg_bank
  import spi_bridge_pkg::*;
(
  input  logic        cs,
  input  logic        rst,
  input  reg_write_t  wr,
  input  logic        wr_valid,
  output board_ctrl_t ctrl
);

  // address hits for the current write
  logic hit_led;
  logic hit_mux;
  logic hit_dac;
  // addr 10 and the right key
  logic hit_soft_reset;

  // next register state
  board_ctrl_t ctrl_next;

  ////////////////////
  // address decode
  ////////////////////

  always_comb
  begin
    hit_led        = 1'b0;
    hit_mux        = 1'b0;
    hit_dac        = 1'b0;
    hit_soft_reset = 1'b0;
    case (wr.addr)
      addr_led:
        hit_led = 1'b1;
      addr_mux:
        hit_mux = 1'b1;
      addr_dac:
        hit_dac = 1'b1;
      // any other byte here is a no-op
      addr_soft_reset:
        hit_soft_reset = (wr.data == soft_reset_key);
      // unmapped, nothing loads
      default:
        hit_soft_reset = 1'b0;
    endcase
  end

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    // hold by default
    ctrl_next = ctrl;
    if (wr_valid)
    begin
      if (hit_soft_reset)
        ctrl_next = '0;
      if (hit_led)
        ctrl_next.led = wr.data;
      if (hit_mux)
        ctrl_next.mux = wr.data;
      // dac gets the low nibble only
      // bits map to ldac, rst, uni_bip_a, uni_bip_b on the board
      if (hit_dac)
        ctrl_next.dac = wr.data[dac_bits-1:0];
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge cs)
  begin
    if (rst)
      ctrl <= '0;
    else
      ctrl <= ctrl_next;
  end

  // ctrl only moves right after a write strobe or a reset
  a_ctrl_quiet: assert property (
    @(posedge cs) disable iff (rst)
    !$past(wr_valid) && !$past(rst) |-> $stable(ctrl)
  );

endmodule

/* logic/cs_router.sv */
`timescale 1ns/100ps

module cs_router
  import spi_bridge_pkg::*;
(
  input  logic                cs,
  input  logic                rst,
  input  spi_pins_t           pins,
  input  logic [mux_bits-1:0] mux,
  output logic [mux_bits-1:0] periph_cs_n,
  output logic                periph_sclk,
  output logic                periph_mosi
);

  // host talks to peripherals right now
  logic pass_active;

  ////////////////////
  // select logic
  ////////////////////

  // pass-through mode and host select asserted
  assign pass_active = pins.reg_access_n & ~pins.ss_n;

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      periph_cs_n <= '1;
      periph_sclk <= 1'b0;
      periph_mosi <= 1'b0;
    end
    else
    begin
      // clock and data go out unchanged
      periph_sclk <= pins.sclk;
      periph_mosi <= pins.mosi;
      // active low, mux bit set means selected
      if (pass_active)
        periph_cs_n <= ~mux;
      else
        periph_cs_n <= '1;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // register writes must never reach a peripheral
  a_reg_mode_isolated: assert property (
    @(posedge cs) disable iff (rst)
    !pins.reg_access_n |=> periph_cs_n == '1
  );

endmodule

/* logic/spi_bridge_top.sv */
`timescale 1ns/100ps

module spi_bridge_top
  import spi_bridge_pkg::*;
(
  input  logic                 cs,
  input  logic                 rst,
  input  logic                 sclk,
  input  logic                 ss_n,
  input  logic                 mosi,
  input  logic                 reg_access_n,
  output logic [byte_bits-1:0] led,
  output logic [dac_bits-1:0]  dac_ctrl,
  output logic [mux_bits-1:0]  periph_cs_n,
  output logic                 periph_sclk,
  output logic                 periph_mosi,
  output logic [byte_bits-1:0] bad_frame_count
);

  // synchronized host pins
  spi_pins_t   pins;
  // decoded frame and its strobe
  reg_write_t  wr;
  logic        wr_valid;
  // board register state
  board_ctrl_t ctrl;

  ////////////////////
  // blocks
  ////////////////////

  spi_frame_rx i_rx (
    .cs              (cs),
    .rst             (rst),
    .sclk            (sclk),
    .ss_n            (ss_n),
    .mosi            (mosi),
    .reg_access_n    (reg_access_n),
    .pins            (pins),
    .wr              (wr),
    .wr_valid        (wr_valid),
    .bad_frame_count (bad_frame_count)
  );

  reg_bank i_regs (
    .cs       (cs),
    .rst      (rst),
    .wr       (wr),
    .wr_valid (wr_valid),
    .ctrl     (ctrl)
  );

  // mux register picks the peripherals
  cs_router i_router (
    .cs          (cs),
    .rst         (rst),
    .pins        (pins),
    .mux         (ctrl.mux),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi)
  );

  // board pins
  assign led      = ctrl.led;
  assign dac_ctrl = ctrl.dac;

endmodule

/* verification/bridge_checker.sv */
`timescale 1ns/100ps

module bridge_checker
  import spi_bridge_pkg::*;
(
  input  logic                 cs,
  input  logic                 rst,
  input  logic                 sclk,
  input  logic                 ss_n,
  input  logic                 mosi,
  input  logic                 reg_access_n,
  input  logic [byte_bits-1:0] led,
  input  logic [dac_bits-1:0]  dac_ctrl,
  input  logic [mux_bits-1:0]  periph_cs_n,
  input  logic                 periph_sclk,
  input  logic                 periph_mosi,
  input  logic [byte_bits-1:0] bad_frame_count,
  output int                   reg_errors,
  output int                   route_errors,
  output int                   gap_checks
);

  // host pins now and at the last three edges with h0 newest
  spi_pins_t now_pins;
  spi_pins_t h0;
  spi_pins_t h1;
  spi_pins_t h2;
  logic      in_reset;

  // frame being rebuilt from the host pins
  logic [frame_bits-1:0] shift;
  int                    bit_cnt;
  logic                  frame_reg_mode;
  int                    idle_cnt;

  // reference model of the board registers
  logic [byte_bits-1:0] led_m;
  logic [mux_bits-1:0]  mux_m;
  logic [dac_bits-1:0]  dac_m;
  logic [byte_bits-1:0] bad_m;
  logic [mux_bits-1:0]  exp_cs_n;

  int reg_err = 0;
  int route_err = 0;
  int gap_cnt = 0;

  assign now_pins = '{sclk: sclk, ss_n: ss_n, mosi: mosi, reg_access_n: reg_access_n};

  assign reg_errors   = reg_err;
  assign route_errors = route_err;
  assign gap_checks   = gap_cnt;

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act,
                            inout int errs);
    if (exp !== act)
    begin
      $display("error %s expected %h actual %h", name, exp, act);
      errs++;
    end
  endtask

  ////////////////////
  // model
  ////////////////////

  always @(posedge cs)
  begin
    in_reset <= rst;
    if (rst)
    begin
      h0             <= pins_idle;
      h1             <= pins_idle;
      h2             <= pins_idle;
      bit_cnt        <= 0;
      frame_reg_mode <= 1'b0;
      idle_cnt       <= 0;
      led_m          <= '0;
      mux_m          <= '0;
      dac_m          <= '0;
      bad_m          <= '0;
    end
    else
    begin
      h0 <= now_pins;
      h1 <= h0;
      h2 <= h1;
      // cycles since the last frame that park well past the check point
      if (now_pins.ss_n)
        idle_cnt <= (idle_cnt < 100) ? idle_cnt + 1 : idle_cnt;
      else
        idle_cnt <= 0;
      // ss_n fall opens a frame and fixes its mode
      if (h0.ss_n && !now_pins.ss_n)
      begin
        bit_cnt        <= 0;
        frame_reg_mode <= ~now_pins.reg_access_n;
      end
      else if (!now_pins.ss_n && h0.sclk && !now_pins.sclk)
      begin
        shift   <= {shift[frame_bits-2:0], now_pins.mosi};
        bit_cnt <= bit_cnt + 1;
      end
      // ss_n rise closes it
      if (!h0.ss_n && now_pins.ss_n)
      begin
        if (frame_reg_mode && bit_cnt == frame_bits)
        begin
          case (shift[15:8])
            addr_led: led_m <= shift[7:0];
            addr_mux: mux_m <= shift[7:0];
            addr_dac: dac_m <= shift[3:0];
            addr_soft_reset:
              if (shift[7:0] == soft_reset_key)
              begin
                led_m <= '0;
                mux_m <= '0;
                dac_m <= '0;
              end
            default: ;
          endcase
        end
        else if (frame_reg_mode && bad_m != bad_count_max)
          bad_m <= bad_m + 8'd1;
      end
    end
  end

  ////////////////////
  // compare
  ////////////////////

  // outputs settled mid cycle
  always @(negedge cs)
  begin
    if (in_reset === 1'b0)
    begin
      // router lags the host pins by two sync stages and its own flop
      if (h2.reg_access_n && !h2.ss_n)
        exp_cs_n = ~mux_m;
      else
        exp_cs_n = '1;
      check_byte("periph_cs_n", exp_cs_n, periph_cs_n, route_err);
      check_byte("periph_sclk", {7'd0, h2.sclk}, {7'd0, periph_sclk}, route_err);
      check_byte("periph_mosi", {7'd0, h2.mosi}, {7'd0, periph_mosi}, route_err);
      // register outputs long settled by now
      if (idle_cnt == 6)
      begin
        check_byte("led", led_m, led, reg_err);
        check_byte("dac_ctrl", {4'd0, dac_m}, {4'd0, dac_ctrl}, reg_err);
        check_byte("bad_frame_count", bad_m, bad_frame_count, reg_err);
        gap_cnt++;
      end
    end
  end

endmodule

/* verification/tb_spi_bridge.sv */
`timescale 1ns/100ps

module tb_spi_bridge
  import spi_bridge_pkg::*;
();

  // run length
  localparam int num_random = 300;
  // enough short frames to pin the bad counter at its max
  localparam int num_burst = 260;
  // longest frame plus its gap stays below this
  localparam int frame_cycles = 120;
  localparam int timeout_cycles = (num_random + num_burst) * frame_cycles + 400;

  // host side pins
  logic cs;
  logic rst;
  logic sclk;
  logic ss_n;
  logic mosi;
  logic reg_access_n;

  // board side pins
  logic [byte_bits-1:0] led;
  logic [dac_bits-1:0]  dac_ctrl;
  logic [mux_bits-1:0]  periph_cs_n;
  logic                 periph_sclk;
  logic                 periph_mosi;
  logic [byte_bits-1:0] bad_frame_count;

  // results from the checker
  int reg_errors;
  int route_errors;
  int gap_checks;

  logic [31:0] lfsr;
  int          frames_sent = 0;

  ////////////////////
  // clock and DUT
  ////////////////////

  initial
  begin
    cs = 1'b0;
    forever #20 cs = ~cs;
  end

  spi_bridge_top i_dut (
    .cs              (cs),
    .rst             (rst),
    .sclk            (sclk),
    .ss_n            (ss_n),
    .mosi            (mosi),
    .reg_access_n    (reg_access_n),
    .led             (led),
    .dac_ctrl        (dac_ctrl),
    .periph_cs_n     (periph_cs_n),
    .periph_sclk     (periph_sclk),
    .periph_mosi     (periph_mosi),
    .bad_frame_count (bad_frame_count)
  );

  // watches the same pins and keeps the model
  bridge_checker i_checker (
    .cs              (cs),
    .rst             (rst),
    .sclk            (sclk),
    .ss_n            (ss_n),
    .mosi            (mosi),
    .reg_access_n    (reg_access_n),
    .led             (led),
    .dac_ctrl        (dac_ctrl),
    .periph_cs_n     (periph_cs_n),
    .periph_sclk     (periph_sclk),
    .periph_mosi     (periph_mosi),
    .bad_frame_count (bad_frame_count),
    .reg_errors      (reg_errors),
    .route_errors    (route_errors),
    .gap_checks      (gap_checks)
  );

  ////////////////////
  // random source
  ////////////////////

  // fibonacci with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit with the newest bit in the lsb
  task automatic rand_bits(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  ////////////////////
  // host SPI driver
  ////////////////////

  // sends nbits msb first out of a 17 bit word with 3 cycle half periods
  task automatic send_frame(input logic reg_mode, input logic [16:0] bits, input int nbits);
    int i;
    @(negedge cs);
    reg_access_n = ~reg_mode;
    @(negedge cs);
    ss_n = 1'b0;
    repeat (3) @(negedge cs);
    for (i = 0; i < nbits; i++)
    begin
      // data set with sclk high and taken on the fall
      mosi = bits[16-i];
      sclk = 1'b1;
      repeat (3) @(negedge cs);
      sclk = 1'b0;
      repeat (3) @(negedge cs);
    end
    ss_n = 1'b1;
    mosi = 1'b0;
    // idle gap where the checker compares
    repeat (8) @(negedge cs);
    frames_sent++;
  endtask

  task automatic random_frame();
    logic [31:0]          r;
    logic                 reg_mode;
    logic [byte_bits-1:0] addr;
    logic [byte_bits-1:0] data;
    int                   nbits;
    // one frame in four goes to the peripherals
    rand_bits(2, r);
    reg_mode = (r[1:0] != 2'd0);
    // mostly the mapped range 7..10
    rand_bits(3, r);
    if (r[2:0] == 3'd7)
    begin
      rand_bits(8, r);
      addr = r[7:0];
    end
    else
    begin
      rand_bits(2, r);
      addr = addr_led + {6'd0, r[1:0]};
    end
    rand_bits(8, r);
    data = r[7:0];
    // half the writes to the reset address carry the key
    if (addr == addr_soft_reset)
    begin
      rand_bits(1, r);
      if (r[0])
        data = soft_reset_key;
    end
    rand_bits(3, r);
    case (r[2:0])
      3'd0: nbits = 15;
      3'd1: nbits = 17;
      default: nbits = 16;
    endcase
    // extra bit only goes out on a 17 bit frame
    rand_bits(1, r);
    send_frame(reg_mode, {addr, data, r[0]}, nbits);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin : stimulus
    int          i;
    int          run_errors;
    int          total;
    logic [31:0] r;
    sclk         = 1'b0;
    ss_n         = 1'b1;
    mosi         = 1'b0;
    reg_access_n = 1'b1;
    rst          = 1'b1;
    run_errors   = 0;
    lfsr         = 32'ha114_040a;
    repeat (5) @(negedge cs);
    rst = 1'b0;
    // quiet stretch so the reset state gets compared
    repeat (10) @(negedge cs);
    for (i = 0; i < num_random; i++)
      random_frame();
    // register mode with the wrong length every time
    for (i = 0; i < num_burst; i++)
    begin
      rand_bits(17, r);
      send_frame(1'b1, r[16:0], (i % 2 == 0) ? 15 : 17);
    end
    repeat (4) @(negedge cs);
    // one gap after reset plus one per frame
    if (gap_checks != frames_sent + 1)
    begin
      $display("only %0d idle gap comparisons made, %0d expected", gap_checks,
               frames_sent + 1);
      run_errors++;
    end
    total = reg_errors + route_errors + run_errors;
    $display("errors: register %0d, routing %0d, run %0d", reg_errors, route_errors,
             run_errors);
    if (total == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // hard stop if the sequence stalls
  initial
  begin : watchdog
    repeat (timeout_cycles) @(posedge cs);
    $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule

/* vlog.f */
logic/spi_bridge_pkg.sv
logic/spi_frame_rx.sv
logic/reg_bank.sv
logic/cs_router.sv
logic/spi_bridge_top.sv
verification/bridge_checker.sv
verification/tb_spi_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SPI bridge testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -f vlog.f --top-module tb_spi_bridge -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "$sim_out" | grep -qF 'All tests passed!'
if [ $? -ne 0 ]; then
  echo "simulation FAILED"
  exit 1
fi

echo "simulation PASSED"
exit 0
